/* common/rasterPkg.sv */
package rasterPkg;

    // Tile geometry
    localparam int tileWidth = 8;
    localparam int tileHeight = 8;

    // Pixel layout, four 4-bit channels
    localparam int subPixelWidth = 4;
    localparam int subPixels = 4;
    localparam int pixelWidth = subPixelWidth * subPixels;

    // Stream beat carries two pixels
    localparam int beatWidth = 32;
    localparam int pixelsPerBeat = beatWidth / pixelWidth;
    localparam int tileBeats = tileWidth * tileHeight / pixelsPerBeat;

    typedef logic [5:0] pixelIndex;
    typedef logic [pixelWidth-1:0] pixel;
    typedef logic [subPixels-1:0] channelMask;

    // Inclusive corners, x0 <= x1 and y0 <= y1
    typedef struct packed {
        logic [2:0] x0;
        logic [2:0] y0;
        logic [2:0] x1;
        logic [2:0] y1;
        pixel color;
        channelMask mask;
    } rectCmd;

    typedef struct packed {
        pixelIndex index;
        pixel color;
        channelMask mask;
        logic enable;
    } fragWrite;

    // Lower pixel index sits in the low half of data
    typedef struct packed {
        logic [beatWidth-1:0] data;
        logic last;
    } streamBeat;

    typedef struct packed {
        pixel color;
        logic lineEnd;
        logic frameEnd;
    } scanPixel;

endpackage

/* framebuffer/dualPortRam.sv */
module dualPortRam #(
    parameter int memWords = 32,
    parameter int memWidth = 32,
    parameter int strobeWidth = 4,
    localparam int addrWidth = $clog2(memWords),
    localparam int strobes = memWidth / strobeWidth
) (
    input  logic                 clk,
    input  logic [memWidth-1:0]  writeData,
    input  logic                 write,
    input  logic [addrWidth-1:0] writeAddr,
    input  logic [strobes-1:0]   writeMask,
    output logic [memWidth-1:0]  readData,
    input  logic [addrWidth-1:0] readAddr
);

    logic [memWidth-1:0] mem [memWords];

    // Lane-masked write port
    always_ff @(posedge clk)
    begin
        if (write)
        begin
            for (int i = 0; i < strobes; i++)
            begin
                if (writeMask[i])
                begin
                    mem[writeAddr][i * strobeWidth +: strobeWidth] <=
                        writeData[i * strobeWidth +: strobeWidth];
                end
            end
        end
    end

    // Registered read, returns the old word on a same-address write
    always_ff @(posedge clk)
    begin
        readData <= mem[readAddr];
    end

endmodule

/* framebuffer/frameBuffer.sv */
module frameBuffer #(
    parameter int tileWidth = rasterPkg::tileWidth,
    parameter int tileHeight = rasterPkg::tileHeight,
    parameter int subPixels = rasterPkg::subPixels,
    parameter int subPixelWidth = rasterPkg::subPixelWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rasterPkg::fragWrite  frag,
    input  rasterPkg::pixelIndex readIndex,
    output rasterPkg::pixel      fragOut,
    input  logic                 apply,
    input  logic                 cmdCommit,
    input  logic                 cmdMemset,
    input  rasterPkg::pixel      clearColor,
    output logic                 applied,
    output rasterPkg::streamBeat beat,
    output logic                 beatValid,
    input  logic                 beatReady
);
    import rasterPkg::*;

    localparam int pixelBits = subPixels * subPixelWidth;
    localparam int lanes = beatWidth / pixelBits;
    localparam int laneBits = $clog2(lanes);
    localparam int beatCount = tileWidth * tileHeight / lanes;
    localparam int addrWidth = $clog2(beatCount);
    localparam int strobes = beatWidth / subPixelWidth;
    localparam logic [addrWidth-1:0] lastBeat = addrWidth'(beatCount - 1);

    typedef enum logic [1:0] {
        stateWait,
        stateCommitInit,
        stateCommit,
        stateMemset
    } cmdState;

    cmdState state;
    logic [addrWidth-1:0] counter;
    logic memsetPending;
    pixel clearHeld;
    logic cmdActive;
    logic beatTaken;

    //////////////////////////////////////////////////////////////////////
    // Fragment port mapping
    //////////////////////////////////////////////////////////////////////

    logic [addrWidth-1:0] fragAddr;
    logic [laneBits-1:0] fragLane;
    logic [strobes-1:0] fragStrobe;
    logic [addrWidth-1:0] readAddr;
    logic [laneBits-1:0] readLaneDelay;

    assign fragAddr = frag.index[laneBits +: addrWidth];
    assign fragLane = frag.index[laneBits-1:0];
    assign readAddr = readIndex[laneBits +: addrWidth];

    // Channel mask lands only in the lane of the addressed pixel
    always_comb
    begin
        for (int i = 0; i < lanes; i++)
        begin
            for (int j = 0; j < subPixels; j++)
            begin
                fragStrobe[i * subPixels + j] = (fragLane == laneBits'(i)) && frag.mask[j];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // RAM port arbitration, commands win
    //////////////////////////////////////////////////////////////////////

    logic [beatWidth-1:0] ramWriteData;
    logic ramWrite;
    logic [addrWidth-1:0] ramWriteAddr;
    logic [strobes-1:0] ramWriteMask;
    logic [beatWidth-1:0] ramReadData;
    logic [addrWidth-1:0] ramReadAddr;
    logic [addrWidth-1:0] commitAddr;

    assign cmdActive = (state != stateWait);
    assign beatTaken = beatValid && beatReady;

    // Look one beat ahead on accept so the stream runs every cycle
    assign commitAddr = beatTaken ? counter + 1'b1 : counter;

    assign ramWrite = cmdActive ? (state == stateMemset) : frag.enable;
    assign ramWriteAddr = cmdActive ? counter : fragAddr;
    assign ramWriteData = cmdActive ? {lanes{clearHeld}} : {lanes{frag.color}};
    assign ramWriteMask = cmdActive ? {strobes{1'b1}} : fragStrobe;
    assign ramReadAddr = cmdActive ? commitAddr : readAddr;

    dualPortRam #(
        .memWords(beatCount),
        .memWidth(beatWidth),
        .strobeWidth(subPixelWidth)
    ) ram_i (
        .clk(clk),
        .writeData(ramWriteData),
        .write(ramWrite),
        .writeAddr(ramWriteAddr),
        .writeMask(ramWriteMask),
        .readData(ramReadData),
        .readAddr(ramReadAddr)
    );

    // Lane select follows the RAM read by one cycle
    always_ff @(posedge clk)
    begin
        readLaneDelay <= readIndex[laneBits-1:0];
        fragOut <= ramReadData[readLaneDelay * pixelBits +: pixelBits];
    end

    assign beat = '{data: ramReadData, last: (counter == lastBeat)};

    //////////////////////////////////////////////////////////////////////
    // Command engine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state == stateWait && apply)
        begin
            clearHeld <= clearColor;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= stateWait;
            counter <= '0;
            memsetPending <= 1'b0;
            beatValid <= 1'b0;
            applied <= 1'b1;
        end
        else
        begin
            case (state)
                stateWait:
                begin
                    counter <= '0;
                    if (apply && (cmdCommit || cmdMemset))
                    begin
                        applied <= 1'b0;
                        memsetPending <= cmdMemset;
                        // Commit goes first when both are requested
                        state <= cmdCommit ? stateCommitInit : stateMemset;
                    end
                end
                stateCommitInit:
                begin
                    // Beat 0 is being read this cycle
                    beatValid <= 1'b1;
                    state <= stateCommit;
                end
                stateCommit:
                begin
                    if (beatTaken)
                    begin
                        counter <= counter + 1'b1;
                        if (counter == lastBeat)
                        begin
                            beatValid <= 1'b0;
                            applied <= !memsetPending;
                            state <= memsetPending ? stateMemset : stateWait;
                        end
                    end
                end
                stateMemset:
                begin
                    counter <= counter + 1'b1;
                    if (counter == lastBeat)
                    begin
                        applied <= 1'b1;
                        state <= stateWait;
                    end
                end
                default:
                begin
                    state <= stateWait;
                end
            endcase
        end
    end

endmodule

/* hw/rectFill.sv */
module rectFill #(
    parameter int tileWidth = rasterPkg::tileWidth,
    parameter int tileHeight = rasterPkg::tileHeight
) (
    input  logic               clk,
    input  logic               reset,
    input  rasterPkg::rectCmd  cmd,
    input  logic               start,
    output logic               busy,
    output rasterPkg::fragWrite frag
);
    import rasterPkg::*;

    localparam int xWidth = $clog2(tileWidth);
    localparam int yWidth = $clog2(tileHeight);

    rectCmd held;
    logic [xWidth-1:0] x;
    logic [yWidth-1:0] y;
    logic lastInRow;
    logic lastInRect;

    assign lastInRow = (x == held.x1);
    assign lastInRect = lastInRow && (y == held.y1);

    // Row-major walk over the latched rectangle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
        end
        else if (!busy)
        begin
            if (start)
            begin
                busy <= 1'b1;
            end
        end
        else if (lastInRect)
        begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy)
        begin
            if (start)
            begin
                held <= cmd;
                x <= cmd.x0;
                y <= cmd.y0;
            end
        end
        else if (lastInRow)
        begin
            // Wrap back to the left edge of the next row
            x <= held.x0;
            y <= y + 1'b1;
        end
        else
        begin
            x <= x + 1'b1;
        end
    end

    // One fragment per busy cycle
    assign frag.index = pixelIndex'(y) * pixelIndex'(tileWidth) + pixelIndex'(x);
    assign frag.color = held.color;
    assign frag.mask = held.mask;
    assign frag.enable = busy;

endmodule

/* hw/scanOut.sv */
module scanOut #(
    parameter int tileWidth = rasterPkg::tileWidth,
    parameter int tileHeight = rasterPkg::tileHeight
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rasterPkg::streamBeat beat,
    input  logic                 beatValid,
    output logic                 beatReady,
    output rasterPkg::scanPixel  pix,
    output logic                 pixelValid,
    input  logic                 pixelReady
);
    import rasterPkg::*;

    localparam int posWidth = $clog2(tileWidth * tileHeight);
    localparam int xWidth = $clog2(tileWidth);
    localparam int laneBits = $clog2(pixelsPerBeat);

    logic [beatWidth-1:0] heldData;
    logic heldLast;
    logic [posWidth-1:0] pos;
    logic [xWidth-1:0] x;
    logic [laneBits-1:0] lane;
    logic lastLane;
    logic beatTaken;
    logic pixelTaken;

    // Position in the frame, low bits give x and the lane
    assign x = pos[xWidth-1:0];
    assign lane = pos[laneBits-1:0];
    assign lastLane = (lane == laneBits'(pixelsPerBeat - 1));

    assign pixelTaken = pixelValid && pixelReady;
    assign beatReady = !pixelValid || (pixelReady && lastLane);
    assign beatTaken = beatValid && beatReady;

    assign pix.color = heldData[lane * pixelWidth +: pixelWidth];
    assign pix.lineEnd = (x == xWidth'(tileWidth - 1));
    assign pix.frameEnd = heldLast && lastLane;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pixelValid <= 1'b0;
            pos <= '0;
        end
        else
        begin
            if (beatTaken)
            begin
                pixelValid <= 1'b1;
            end
            else if (pixelTaken && lastLane)
            begin
                pixelValid <= 1'b0;
            end

            // Realign on the end of a frame
            if (pixelTaken)
            begin
                pos <= pix.frameEnd ? '0 : pos + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (beatTaken)
        begin
            heldData <= beat.data;
            heldLast <= beat.last;
        end
    end

endmodule

/* hw/rasterSubsystem.sv */
module rasterSubsystem #(
    parameter int tileWidth = rasterPkg::tileWidth,
    parameter int tileHeight = rasterPkg::tileHeight,
    parameter int subPixels = rasterPkg::subPixels,
    parameter int subPixelWidth = rasterPkg::subPixelWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rasterPkg::rectCmd    rectCmd,
    input  logic                 rectStart,
    output logic                 rectBusy,
    input  logic                 apply,
    input  logic                 cmdCommit,
    input  logic                 cmdMemset,
    input  rasterPkg::pixel      clearColor,
    output logic                 applied,
    input  rasterPkg::pixelIndex readIndex,
    output rasterPkg::pixel      fragOut,
    output rasterPkg::scanPixel  pix,
    output logic                 pixelValid,
    input  logic                 pixelReady
);
    import rasterPkg::*;

    fragWrite frag;
    streamBeat beat;
    logic beatValid;
    logic beatReady;

    rectFill #(
        .tileWidth(tileWidth),
        .tileHeight(tileHeight)
    ) rectFill_i (
        .clk(clk),
        .reset(reset),
        .cmd(rectCmd),
        .start(rectStart),
        .busy(rectBusy),
        .frag(frag)
    );

    frameBuffer #(
        .tileWidth(tileWidth),
        .tileHeight(tileHeight),
        .subPixels(subPixels),
        .subPixelWidth(subPixelWidth)
    ) frameBuffer_i (
        .clk(clk),
        .reset(reset),
        .frag(frag),
        .readIndex(readIndex),
        .fragOut(fragOut),
        .apply(apply),
        .cmdCommit(cmdCommit),
        .cmdMemset(cmdMemset),
        .clearColor(clearColor),
        .applied(applied),
        .beat(beat),
        .beatValid(beatValid),
        .beatReady(beatReady)
    );

    scanOut #(
        .tileWidth(tileWidth),
        .tileHeight(tileHeight)
    ) scanOut_i (
        .clk(clk),
        .reset(reset),
        .beat(beat),
        .beatValid(beatValid),
        .beatReady(beatReady),
        .pix(pix),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady)
    );

endmodule

/* bench/rasterSubsystemTb.sv */
module rasterSubsystemTb;
    import rasterPkg::*;

    typedef enum logic [2:0] {
        caseRect,
        caseMemset,
        caseCommit,
        caseBoth,
        caseRead
    } caseOp;

    typedef struct packed {
        caseOp op;
        rectCmd rect;
        pixel color;
        pixelIndex index;
    } caseEntry;

    logic clk = 1'b0;
    logic reset;
    rectCmd rectReq;
    logic rectStart;
    logic rectBusy;
    logic apply;
    logic cmdCommit;
    logic cmdMemset;
    pixel clearColor;
    logic applied;
    pixelIndex readIndex;
    pixel fragOut;
    scanPixel pix;
    logic pixelValid;
    logic pixelReady = 1'b0;

    int seed;
    logic casesLoaded;
    caseEntry cases[$];
    // Expected tile contents, row-major
    pixel tileRef [tileWidth * tileHeight];

    rasterSubsystem dut_i (
        .clk(clk),
        .reset(reset),
        .rectCmd(rectReq),
        .rectStart(rectStart),
        .rectBusy(rectBusy),
        .apply(apply),
        .cmdCommit(cmdCommit),
        .cmdMemset(cmdMemset),
        .clearColor(clearColor),
        .applied(applied),
        .readIndex(readIndex),
        .fragOut(fragOut),
        .pix(pix),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady)
    );

    always #5 clk = ~clk;

    // Display side stalls about one cycle in four
    always @(posedge clk)
    begin
        pixelReady <= ($random(seed) & 3) != 0;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkPixel(input string name, input pixel expected, input pixel actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected,
                actual);
            abortRun();
        end
    endtask

    task automatic checkScan(input string name, input scanPixel expected,
        input scanPixel actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t %s expected color %h lineEnd %b frameEnd %b", $time,
                name, expected.color, expected.lineEnd, expected.frameEnd);
            $display("MISMATCH time %0t %s actual color %h lineEnd %b frameEnd %b", $time,
                name, actual.color, actual.lineEnd, actual.frameEnd);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input bit expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t %s expected %b actual %b", $time, name, expected,
                actual);
            abortRun();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case file
    //////////////////////////////////////////////////////////////////////

    task automatic loadCases();
        int fd;
        int got;
        int need;
        int x0, y0, x1, y1;
        int index;
        logic [63:0] word;
        logic [8*120-1:0] rest;
        pixel color;
        channelMask mask;
        caseEntry entry;
        fd = $fopen("bench/rasterCases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file bench/rasterCases.txt");
            abortRun();
        end
        while ($fscanf(fd, "%s", word) == 1)
        begin
            if (word == 64'("#"))
            begin
                got = $fgets(rest, fd);
            end
            else
            begin
                entry = '0;
                need = 0;
                got = 0;
                if (word == 64'("rect"))
                begin
                    need = 6;
                    got = $fscanf(fd, "%d %d %d %d %h %h", x0, y0, x1, y1, color, mask);
                    entry.op = caseRect;
                    entry.rect = '{x0: 3'(x0), y0: 3'(y0), x1: 3'(x1), y1: 3'(y1),
                        color: color, mask: mask};
                end
                else if (word == 64'("memset") || word == 64'("both"))
                begin
                    need = 1;
                    got = $fscanf(fd, "%h", color);
                    entry.op = (word == 64'("both")) ? caseBoth : caseMemset;
                    entry.color = color;
                end
                else if (word == 64'("commit"))
                begin
                    entry.op = caseCommit;
                end
                else if (word == 64'("read"))
                begin
                    need = 1;
                    got = $fscanf(fd, "%d", index);
                    entry.op = caseRead;
                    entry.index = pixelIndex'(index);
                end
                else
                begin
                    $display("Unknown operation %0s in the case file", word);
                    abortRun();
                end
                if (got != need)
                begin
                    $display("Case %0d in the case file has missing fields", cases.size());
                    abortRun();
                end
                cases.push_back(entry);
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////////////////////////

    task automatic runRect(input rectCmd r);
        int x0i;
        int x1i;
        int y0i;
        int y1i;
        x0i = int'(r.x0);
        x1i = int'(r.x1);
        y0i = int'(r.y0);
        y1i = int'(r.y1);
        @(posedge clk);
        rectReq <= r;
        rectStart <= 1'b1;
        @(posedge clk);
        rectStart <= 1'b0;
        // Busy lasts one cycle per fragment
        for (int i = 0; i < (x1i - x0i + 1) * (y1i - y0i + 1); i++)
        begin
            @(negedge clk);
            checkFlag("rectBusy", 1'b1, rectBusy);
        end
        @(negedge clk);
        checkFlag("rectBusy", 1'b0, rectBusy);
        for (int y = y0i; y <= y1i; y++)
        begin
            for (int x = x0i; x <= x1i; x++)
            begin
                for (int c = 0; c < subPixels; c++)
                begin
                    if (r.mask[c])
                    begin
                        tileRef[pixelIndex'(y * tileWidth + x)][c * subPixelWidth +:
                            subPixelWidth] = r.color[c * subPixelWidth +: subPixelWidth];
                    end
                end
            end
        end
    endtask

    task automatic runRead(input pixelIndex index);
        @(posedge clk);
        readIndex <= index;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkPixel("fragOut", tileRef[index], fragOut);
    endtask

    // Takes the whole frame in row-major order, rechecking a stalled pixel each cycle
    task automatic collectFrame();
        int k;
        scanPixel expected;
        k = 0;
        while (k < tileWidth * tileHeight)
        begin
            @(negedge clk);
            if (pixelValid)
            begin
                expected.color = tileRef[pixelIndex'(k)];
                expected.lineEnd = (k % tileWidth) == tileWidth - 1;
                expected.frameEnd = k == tileWidth * tileHeight - 1;
                checkScan("pix", expected, pix);
                if (pixelReady)
                begin
                    k++;
                end
            end
        end
    endtask

    task automatic runCommand(input logic commit, input logic memset, input pixel color);
        @(posedge clk);
        apply <= 1'b1;
        cmdCommit <= commit;
        cmdMemset <= memset;
        clearColor <= color;
        @(posedge clk);
        apply <= 1'b0;
        @(negedge clk);
        checkFlag("applied", 1'b0, applied);
        if (commit)
        begin
            collectFrame();
        end
        // Memset lands after the commit has streamed the old tile
        if (memset)
        begin
            foreach (tileRef[i])
            begin
                tileRef[i] = color;
            end
        end
        while (!applied)
        begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed = 32'h600d;
        reset = 1'b1;
        rectReq = '0;
        rectStart = 1'b0;
        apply = 1'b0;
        cmdCommit = 1'b0;
        cmdMemset = 1'b0;
        clearColor = '0;
        readIndex = '0;
        loadCases();
        casesLoaded = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkFlag("applied", 1'b1, applied);
        checkFlag("rectBusy", 1'b0, rectBusy);
        checkFlag("pixelValid", 1'b0, pixelValid);
        foreach (cases[i])
        begin
            case (cases[i].op)
                caseRect: runRect(cases[i].rect);
                caseMemset: runCommand(1'b0, 1'b1, cases[i].color);
                caseCommit: runCommand(1'b1, 1'b0, cases[i].color);
                caseBoth: runCommand(1'b1, 1'b1, cases[i].color);
                caseRead: runRead(cases[i].index);
                default:
                begin
                    $display("Case %0d has an unknown operation code", i);
                    abortRun();
                end
            endcase
        end
        $display("No errors");
        $finish;
    end

    initial
    begin
        wait (casesLoaded === 1'b1);
        repeat (cases.size() * 400) @(posedge clk);
        $display("The run timed out after %0d cycles", cases.size() * 400);
        abortRun();
    end

endmodule

/* bench/rasterCases.txt */
# rect x0 y0 x1 y1 color mask, memset color, commit, both color, read index
# colors and masks are hex, corners and indices are decimal
memset 1234
commit
rect 1 1 4 3 abcd f
read 9
read 28
read 0
read 36
rect 3 2 7 6 5e70 5
read 19
read 55
rect 0 0 7 0 9999 8
read 2
rect 6 5 6 7 0f0f 3
read 62
commit
both c3a5
read 12
read 63
commit
read 0

/* src.f */
common/rasterPkg.sv
framebuffer/dualPortRam.sv
framebuffer/frameBuffer.sv
hw/rectFill.sv
hw/scanOut.sv
hw/rasterSubsystem.sv
bench/rasterSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the raster subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rasterSubsystemTb \
    --Mdir obj_dir -o rasterSubsystemTb -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/rasterSubsystemTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
